// File: logic/apb_ss_pkg.sv
//====================================================================
// APB subsystem shared definitions
// Address map, register offsets, bus widths and protocol codes
//====================================================================
`default_nettype none

package apb_ss_pkg;

  // Bus widths
  localparam int AHB_ADDR_W = 32;
  localparam int AHB_DATA_W = 32;
  localparam int PADDR_W    = 2;          // Word offset inside a slot
  localparam int GPIO_W     = 16;

  // 4 KB slot decode on haddr[15:12]
  localparam int                SLOT_LSB  = 12;
  localparam int                SLOT_W    = 4;
  localparam int                OFS_LSB   = 2;
  localparam logic [SLOT_W-1:0] SLOT_GPIO = 4'd0;
  localparam logic [SLOT_W-1:0] SLOT_SPI  = 4'd1;

  // GPIO register offsets
  localparam logic [PADDR_W-1:0] GPIO_OUT_OFS = 2'd0;
  localparam logic [PADDR_W-1:0] GPIO_OE_OFS  = 2'd1;
  localparam logic [PADDR_W-1:0] GPIO_IN_OFS  = 2'd2;
  localparam logic [PADDR_W-1:0] GPIO_INT_OFS = 2'd3;

  // SPI register offsets
  localparam logic [PADDR_W-1:0] SPI_CTRL_OFS = 2'd0;
  localparam logic [PADDR_W-1:0] SPI_TX_OFS   = 2'd1;
  localparam logic [PADDR_W-1:0] SPI_RX_OFS   = 2'd2;
  localparam logic [PADDR_W-1:0] SPI_STAT_OFS = 2'd3;

  // AHB transfer types and responses
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;
  localparam logic [1:0] HRESP_OKAY    = 2'b00;
  localparam logic [1:0] HRESP_ERROR   = 2'b01;

  // SPI frame and control fields
  localparam int SPI_DIV_W  = 8;
  localparam int SPI_BITS   = 8;
  localparam int SPI_CNT_W  = 3;          // Bit counter, log2 of SPI_BITS
  localparam int SPI_EN_BIT = 8;          // Enable sits just above the divider

  // Bridge FSM states
  localparam int                    BR_STATE_W = 3;
  localparam logic [BR_STATE_W-1:0] BR_IDLE    = 3'd0;
  localparam logic [BR_STATE_W-1:0] BR_SETUP   = 3'd1;
  localparam logic [BR_STATE_W-1:0] BR_ACCESS  = 3'd2;
  localparam logic [BR_STATE_W-1:0] BR_ERR1    = 3'd3;   // hready low, ERROR
  localparam logic [BR_STATE_W-1:0] BR_ERR2    = 3'd4;   // hready high, ERROR

endpackage

`default_nettype wire

// File: logic/ahb_apb_bridge.sv
//====================================================================
// AHB-Lite to APB bridge
// Single word transfers, 4 KB slot decode, two-cycle error response
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module ahb_apb_bridge
  import apb_ss_pkg::*;
(
  input  logic                  tb_hclk27,
  input  logic                  hresetn27,
  // AHB-Lite slave side
  input  logic                  i_hsel,
  input  logic [AHB_ADDR_W-1:0] i_haddr,
  input  logic [1:0]            i_htrans,
  input  logic                  i_hwrite,
  input  logic [AHB_DATA_W-1:0] i_hwdata,
  input  logic                  i_hready_in,
  output logic [AHB_DATA_W-1:0] o_hrdata,
  output logic                  o_hready,
  output logic [1:0]            o_hresp,
  // APB master side
  output logic [PADDR_W-1:0]    o_paddr,
  output logic                  o_pwrite,
  output logic [AHB_DATA_W-1:0] o_pwdata,
  output logic                  o_psel_gpio,
  output logic                  o_psel_spi,
  output logic                  o_penable,
  input  logic [AHB_DATA_W-1:0] i_prdata_gpio,
  input  logic [AHB_DATA_W-1:0] i_prdata_spi
);

  logic [BR_STATE_W-1:0] state_q;
  logic [BR_STATE_W-1:0] state_d;
  logic                  trans_ok;
  logic                  hready_int;
  logic                  accept;
  logic [SLOT_W-1:0]     slot;
  logic                  hit_gpio;
  logic                  hit_spi;
  logic                  write_q;
  logic                  sel_gpio_q;
  logic                  sel_spi_q;
  logic [PADDR_W-1:0]    paddr_q;
  logic [AHB_DATA_W-1:0] pwdata_q;
  logic [AHB_DATA_W-1:0] hrdata_q;
  logic [AHB_DATA_W-1:0] prdata_mux;

  // ==================================================================
  // Address phase
  // ==================================================================
  always_comb begin
    case (i_htrans)
      HTRANS_NONSEQ, HTRANS_SEQ: trans_ok = 1'b1;
      HTRANS_IDLE, HTRANS_BUSY:  trans_ok = 1'b0;   // No transfer to serve
      default:                   trans_ok = 1'b0;
    endcase
  end

  // Ready in idle and in the last error cycle
  assign hready_int = (state_q == BR_IDLE) || (state_q == BR_ERR2);
  assign accept     = i_hsel && i_hready_in && trans_ok && hready_int;

  assign slot     = i_haddr[SLOT_LSB +: SLOT_W];
  assign hit_gpio = (slot == SLOT_GPIO);
  assign hit_spi  = (slot == SLOT_SPI);

  // ==================================================================
  // Transfer FSM
  // ==================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      BR_SETUP:  state_d = BR_ACCESS;
      BR_ACCESS: state_d = BR_IDLE;
      BR_ERR1:   state_d = BR_ERR2;
      default: begin                          // Idle or error tail
        if (accept) begin
          state_d = (hit_gpio || hit_spi) ? BR_SETUP : BR_ERR1;
        end else begin
          state_d = BR_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge tb_hclk27) begin
    if (!hresetn27) begin
      state_q    <= BR_IDLE;
      write_q    <= 1'b0;
      sel_gpio_q <= 1'b0;
      sel_spi_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        write_q    <= i_hwrite;
        sel_gpio_q <= hit_gpio;             // Both low on unmapped slot
        sel_spi_q  <= hit_spi;
      end
    end
  end

  // Payload: offset, write data, read data
  always_ff @(posedge tb_hclk27) begin
    if (accept) begin
      paddr_q <= i_haddr[OFS_LSB +: PADDR_W];
    end
    if (state_q == BR_SETUP) begin
      pwdata_q <= i_hwdata;                 // First data-phase cycle
    end
    if ((state_q == BR_ACCESS) && !write_q) begin
      hrdata_q <= prdata_mux;
    end
  end

  // ==================================================================
  // APB drive and AHB response
  // ==================================================================
  assign prdata_mux = sel_spi_q ? i_prdata_spi : i_prdata_gpio;

  assign o_paddr     = paddr_q;
  assign o_pwrite    = write_q;
  assign o_pwdata    = (state_q == BR_SETUP) ? i_hwdata : pwdata_q;
  assign o_penable   = (state_q == BR_ACCESS);
  assign o_psel_gpio = sel_gpio_q && ((state_q == BR_SETUP) || (state_q == BR_ACCESS));
  assign o_psel_spi  = sel_spi_q && ((state_q == BR_SETUP) || (state_q == BR_ACCESS));

  assign o_hready = hready_int;
  assign o_hrdata = hrdata_q;
  assign o_hresp  = ((state_q == BR_ERR1) || (state_q == BR_ERR2)) ? HRESP_ERROR : HRESP_OKAY;

endmodule

`default_nettype wire

// File: logic/apb_gpio.sv
//====================================================================
// APB GPIO, 16 pins
// Output and enable registers, synchronized input, edge interrupts
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module apb_gpio
  import apb_ss_pkg::*;
(
  input  logic                  tb_hclk27,
  input  logic                  hresetn27,
  input  logic                  i_psel,
  input  logic                  i_penable,
  input  logic                  i_pwrite,
  input  logic [PADDR_W-1:0]    i_paddr,
  input  logic [AHB_DATA_W-1:0] i_pwdata,
  output logic [AHB_DATA_W-1:0] o_prdata,
  input  logic [GPIO_W-1:0]     i_gpio_in,
  output logic [GPIO_W-1:0]     o_gpio_out,
  output logic [GPIO_W-1:0]     o_gpio_n_oe,
  output logic                  o_irq
);

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;                   // 1 drives the pin
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] in_q;                   // IN register
  logic [GPIO_W-1:0] in_d_q;                 // IN one cycle back
  logic [GPIO_W-1:0] int_q;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] int_clr;
  logic              wr_en;

  // Write at end of access cycle
  assign wr_en = i_psel && i_penable && i_pwrite;

  assign rise    = in_q & ~in_d_q;
  assign int_clr = (wr_en && (i_paddr == GPIO_INT_OFS)) ? i_pwdata[GPIO_W-1:0] : '0;

  // ==================================================================
  // Registers
  // ==================================================================
  always_ff @(posedge tb_hclk27) begin
    if (!hresetn27) begin
      out_q   <= '0;
      oe_q    <= '0;                         // All pins tri-stated
      sync1_q <= '0;
      sync2_q <= '0;
      in_q    <= '0;
      in_d_q  <= '0;
      int_q   <= '0;
    end else begin
      sync1_q <= i_gpio_in;                  // Two-flop synchronizer
      sync2_q <= sync1_q;
      in_q    <= sync2_q;
      in_d_q  <= in_q;
      // New edge wins over a clear in the same cycle
      int_q   <= (int_q & ~int_clr) | rise;
      if (wr_en && (i_paddr == GPIO_OUT_OFS)) begin
        out_q <= i_pwdata[GPIO_W-1:0];
      end
      if (wr_en && (i_paddr == GPIO_OE_OFS)) begin
        oe_q <= i_pwdata[GPIO_W-1:0];
      end
    end
  end

  // ==================================================================
  // Read mux and pins
  // ==================================================================
  always_comb begin
    o_prdata = '0;
    case (i_paddr)
      GPIO_OUT_OFS: o_prdata[GPIO_W-1:0] = out_q;
      GPIO_OE_OFS:  o_prdata[GPIO_W-1:0] = oe_q;
      GPIO_IN_OFS:  o_prdata[GPIO_W-1:0] = in_q;
      GPIO_INT_OFS: o_prdata[GPIO_W-1:0] = int_q;
      default:      o_prdata = '0;
    endcase
  end

  assign o_gpio_out  = out_q;
  assign o_gpio_n_oe = ~oe_q;                // Active-low enable
  assign o_irq       = |int_q;

endmodule

`default_nettype wire

// File: logic/apb_spi_master.sv
//====================================================================
// APB SPI master, mode 0, 8-bit frames, one slave select
// Divider sets each SCLK half-period to div+1 clocks
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module apb_spi_master
  import apb_ss_pkg::*;
(
  input  logic                  tb_hclk27,
  input  logic                  hresetn27,
  input  logic                  i_psel,
  input  logic                  i_penable,
  input  logic                  i_pwrite,
  input  logic [PADDR_W-1:0]    i_paddr,
  input  logic [AHB_DATA_W-1:0] i_pwdata,
  output logic [AHB_DATA_W-1:0] o_prdata,
  output logic                  o_sclk,
  output logic                  o_mosi,
  output logic                  o_n_ss,
  input  logic                  i_miso,
  output logic                  o_irq
);

  logic [SPI_DIV_W-1:0] div_q;
  logic                 en_q;
  logic [SPI_BITS-1:0]  tx_q;
  logic [SPI_BITS-1:0]  rx_q;
  logic [SPI_BITS-1:0]  shift_q;            // TX out at MSB, RX in at LSB
  logic                 miso_q;             // Sampled on rising SCLK
  logic [SPI_DIV_W-1:0] div_cnt_q;
  logic [SPI_CNT_W-1:0] bit_cnt_q;
  logic                 busy_q;
  logic                 done_q;
  logic                 sclk_q;
  logic                 n_ss_q;
  logic                 wr_en;
  logic                 rd_rx;
  logic                 start;
  logic                 half_done;
  logic                 frame_end;

  assign wr_en     = i_psel && i_penable && i_pwrite;
  assign rd_rx     = i_psel && i_penable && !i_pwrite && (i_paddr == SPI_RX_OFS);
  assign start     = wr_en && (i_paddr == SPI_TX_OFS) && en_q && !busy_q;
  assign half_done = busy_q && (div_cnt_q == div_q);
  // Last falling edge closes the frame
  assign frame_end = half_done && sclk_q && (bit_cnt_q == SPI_CNT_W'(SPI_BITS - 1));

  // ==================================================================
  // Control, shifter and status
  // ==================================================================
  always_ff @(posedge tb_hclk27) begin
    if (!hresetn27) begin
      div_q     <= '0;
      en_q      <= 1'b0;
      tx_q      <= '0;
      rx_q      <= '0;
      shift_q   <= '0;
      miso_q    <= 1'b0;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      sclk_q    <= 1'b0;
      n_ss_q    <= 1'b1;
    end else begin
      if (wr_en && (i_paddr == SPI_CTRL_OFS)) begin
        div_q <= i_pwdata[SPI_DIV_W-1:0];
        en_q  <= i_pwdata[SPI_EN_BIT];
      end
      if (start) begin
        tx_q      <= i_pwdata[SPI_BITS-1:0];
        shift_q   <= i_pwdata[SPI_BITS-1:0];  // MSB on MOSI at once
        busy_q    <= 1'b1;
        n_ss_q    <= 1'b0;
        sclk_q    <= 1'b0;
        div_cnt_q <= '0;
        bit_cnt_q <= '0;
      end else if (busy_q) begin
        if (half_done) begin
          div_cnt_q <= '0;
          sclk_q    <= ~sclk_q;
          if (!sclk_q) begin
            miso_q <= i_miso;                 // Rising edge
          end else begin
            shift_q   <= {shift_q[SPI_BITS-2:0], miso_q};   // Falling edge
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
          if (frame_end) begin
            rx_q   <= {shift_q[SPI_BITS-2:0], miso_q};
            busy_q <= 1'b0;
            n_ss_q <= 1'b1;
          end
        end else begin
          div_cnt_q <= div_cnt_q + 1'b1;
        end
      end
      // Sticky done, reading RX clears it
      if (frame_end) begin
        done_q <= 1'b1;
      end else if (rd_rx) begin
        done_q <= 1'b0;
      end
    end
  end

  // ==================================================================
  // Read mux and pins
  // ==================================================================
  always_comb begin
    o_prdata = '0;
    case (i_paddr)
      SPI_CTRL_OFS: o_prdata[SPI_EN_BIT:0] = {en_q, div_q};
      SPI_TX_OFS:   o_prdata[SPI_BITS-1:0] = tx_q;
      SPI_RX_OFS:   o_prdata[SPI_BITS-1:0] = rx_q;
      SPI_STAT_OFS: o_prdata[1:0]          = {done_q, busy_q};
      default:      o_prdata = '0;
    endcase
  end

  assign o_sclk = sclk_q;
  assign o_mosi = shift_q[SPI_BITS-1];
  assign o_n_ss = n_ss_q;
  assign o_irq  = done_q;

endmodule

`default_nettype wire

// File: logic/apb_subsystem.sv
//====================================================================
// APB subsystem top
// AHB-Lite slave port into the bridge, GPIO and SPI on the APB side
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module apb_subsystem
  import apb_ss_pkg::*;
(
  input  logic                  tb_hclk27,
  input  logic                  hresetn27,
  // AHB-Lite slave port
  input  logic                  i_hsel,
  input  logic [AHB_ADDR_W-1:0] i_haddr,
  input  logic [1:0]            i_htrans,
  input  logic                  i_hwrite,
  input  logic [AHB_DATA_W-1:0] i_hwdata,
  input  logic                  i_hready_in,
  output logic [AHB_DATA_W-1:0] o_hrdata,
  output logic                  o_hready,
  output logic [1:0]            o_hresp,
  // GPIO pins
  input  logic [GPIO_W-1:0]     i_gpio_in,
  output logic [GPIO_W-1:0]     o_gpio_out,
  output logic [GPIO_W-1:0]     o_gpio_n_oe,
  // SPI pins
  output logic                  o_sclk,
  output logic                  o_mosi,
  output logic                  o_n_ss,
  input  logic                  i_miso,
  // Interrupts
  output logic                  o_gpio_irq,
  output logic                  o_spi_irq
);

  // Shared APB lines
  logic [PADDR_W-1:0]    paddr;
  logic                  pwrite;
  logic [AHB_DATA_W-1:0] pwdata;
  logic                  penable;
  // Per-slot select and read data
  logic                  psel_gpio;
  logic                  psel_spi;
  logic [AHB_DATA_W-1:0] prdata_gpio;
  logic [AHB_DATA_W-1:0] prdata_spi;

  ahb_apb_bridge ahb_apb_bridge_inst (
    .tb_hclk27     (tb_hclk27),
    .hresetn27     (hresetn27),
    .i_hsel        (i_hsel),
    .i_haddr       (i_haddr),
    .i_htrans      (i_htrans),
    .i_hwrite      (i_hwrite),
    .i_hwdata      (i_hwdata),
    .i_hready_in   (i_hready_in),
    .o_hrdata      (o_hrdata),
    .o_hready      (o_hready),
    .o_hresp       (o_hresp),
    .o_paddr       (paddr),
    .o_pwrite      (pwrite),
    .o_pwdata      (pwdata),
    .o_psel_gpio   (psel_gpio),
    .o_psel_spi    (psel_spi),
    .o_penable     (penable),
    .i_prdata_gpio (prdata_gpio),
    .i_prdata_spi  (prdata_spi)
  );

  apb_gpio apb_gpio_inst (                   // Slot 0
    .tb_hclk27   (tb_hclk27),
    .hresetn27   (hresetn27),
    .i_psel      (psel_gpio),
    .i_penable   (penable),
    .i_pwrite    (pwrite),
    .i_paddr     (paddr),
    .i_pwdata    (pwdata),
    .o_prdata    (prdata_gpio),
    .i_gpio_in   (i_gpio_in),
    .o_gpio_out  (o_gpio_out),
    .o_gpio_n_oe (o_gpio_n_oe),
    .o_irq       (o_gpio_irq)
  );

  apb_spi_master apb_spi_master_inst (       // Slot 1
    .tb_hclk27 (tb_hclk27),
    .hresetn27 (hresetn27),
    .i_psel    (psel_spi),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata_spi),
    .o_sclk    (o_sclk),
    .o_mosi    (o_mosi),
    .o_n_ss    (o_n_ss),
    .i_miso    (i_miso),
    .o_irq     (o_spi_irq)
  );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
//====================================================================
// Testbench clock and reset source
// 10 ns clock, synchronous active-low reset held for 16 cycles
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic tb_hclk27,
  output logic hresetn27
);

  localparam int RESET_CYCLES = 16;

  initial begin
    tb_hclk27 = 1'b0;
    forever #5 tb_hclk27 = ~tb_hclk27;      // 100 MHz
  end

  initial begin
    hresetn27 = 1'b0;
    repeat (RESET_CYCLES) @(posedge tb_hclk27);
    #1;                                      // Released just after an edge
    hresetn27 = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/apb_subsystem_properties.sv
//====================================================================
// AHB and APB protocol assertions for the bridge
// Setup before access, one-hot select, two-cycle error response
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module apb_subsystem_properties
  import apb_ss_pkg::*;
(
  input logic       tb_hclk27,
  input logic       hresetn27,
  input logic       i_hready,
  input logic [1:0] i_hresp,
  input logic       i_psel_gpio,
  input logic       i_psel_spi,
  input logic       i_penable
);

  logic psel_any;

  assign psel_any = i_psel_gpio || i_psel_spi;

  // Access cycle only right after a setup cycle
  penable_after_setup: assert property (@(posedge tb_hclk27) disable iff (!hresetn27)
    i_penable |-> psel_any && $past(psel_any) && !$past(i_penable))
    else $error("APB access cycle without a setup cycle before it");

  sel_one_hot: assert property (@(posedge tb_hclk27) disable iff (!hresetn27)
    $onehot0({i_psel_gpio, i_psel_spi}))
    else $error("More than one APB select high");

  // First error cycle stalls, second one releases
  err_second_cycle: assert property (@(posedge tb_hclk27) disable iff (!hresetn27)
    (i_hresp == HRESP_ERROR && !i_hready) |=> (i_hresp == HRESP_ERROR && i_hready))
    else $error("AHB error response did not end with hready high");

  err_first_cycle: assert property (@(posedge tb_hclk27) disable iff (!hresetn27)
    (i_hresp == HRESP_ERROR && i_hready) |-> $past(i_hresp == HRESP_ERROR && !i_hready))
    else $error("AHB error response skipped its stall cycle");

  err_no_select: assert property (@(posedge tb_hclk27) disable iff (!hresetn27)
    (i_hresp == HRESP_ERROR) |-> !psel_any)
    else $error("APB select raised during an error response");

endmodule

bind ahb_apb_bridge apb_subsystem_properties apb_subsystem_properties_inst (
  .tb_hclk27   (tb_hclk27),
  .hresetn27   (hresetn27),
  .i_hready    (o_hready),
  .i_hresp     (o_hresp),
  .i_psel_gpio (o_psel_gpio),
  .i_psel_spi  (o_psel_spi),
  .i_penable   (o_penable)
);

`default_nettype wire

// File: dv/apb_subsystem_tb.sv
//====================================================================
// APB subsystem testbench
// AHB master tasks, GPIO and SPI models, random checks, watchdog
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module apb_subsystem_tb
  import apb_ss_pkg::*;
();

  localparam int                    NUM_FRAMES  = 7;     // Loopback plus busy frame
  localparam int                    TIMEOUT_CYC = 4000 + 200 * NUM_FRAMES;
  localparam logic [AHB_ADDR_W-1:0] GPIO_BASE   = 32'h0000_0000;
  localparam logic [AHB_ADDR_W-1:0] SPI_BASE    = 32'h0000_1000;

  logic                  tb_hclk27;
  logic                  hresetn27;
  logic                  hsel;
  logic [AHB_ADDR_W-1:0] haddr;
  logic [1:0]            htrans;
  logic                  hwrite;
  logic [AHB_DATA_W-1:0] hwdata;
  logic                  hready_in;
  logic [AHB_DATA_W-1:0] hrdata;
  logic                  hready;
  logic [1:0]            hresp;
  logic [GPIO_W-1:0]     gpio_in;
  logic [GPIO_W-1:0]     gpio_out;
  logic [GPIO_W-1:0]     gpio_n_oe;
  logic                  sclk;
  logic                  mosi;
  logic                  n_ss;
  logic                  miso;
  logic                  gpio_irq;
  logic                  spi_irq;

  // Models
  logic [GPIO_W-1:0]     gpio_regs [4];         // Indexed by register offset
  logic [SPI_BITS-1:0]   spi_q [$];             // Bytes sent, not yet read back
  logic [SPI_DIV_W-1:0]  spi_div;
  int                    err_count;
  int                    check_count;
  int                    ss_low_cycles = 0;

  assign miso = mosi;                            // Loopback

  tb_clock_gen tb_clock_gen_inst (
    .tb_hclk27 (tb_hclk27),
    .hresetn27 (hresetn27)
  );

  apb_subsystem apb_subsystem_inst (
    .tb_hclk27 (tb_hclk27),   .hresetn27 (hresetn27),
    .i_hsel (hsel),           .i_haddr (haddr),         .i_htrans (htrans),
    .i_hwrite (hwrite),       .i_hwdata (hwdata),       .i_hready_in (hready_in),
    .o_hrdata (hrdata),       .o_hready (hready),       .o_hresp (hresp),
    .i_gpio_in (gpio_in),     .o_gpio_out (gpio_out),   .o_gpio_n_oe (gpio_n_oe),
    .o_sclk (sclk),           .o_mosi (mosi),           .o_n_ss (n_ss),
    .i_miso (miso),           .o_gpio_irq (gpio_irq),   .o_spi_irq (spi_irq)
  );

  // ==================================================================
  // Checks and AHB driver
  // ==================================================================
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("ERR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  function automatic logic [AHB_ADDR_W-1:0] reg_addr(input logic [AHB_ADDR_W-1:0] base,
                                                      input logic [PADDR_W-1:0] ofs);
    return base | {28'h0, ofs, 2'b00};
  endfunction

  // One single transfer, entered 1 ns after an edge with hready high
  task automatic ahb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic [1:0] resp);
    int waits;
    hsel   = 1'b1;
    haddr  = addr;
    htrans = HTRANS_NONSEQ;
    hwrite = write;
    @(posedge tb_hclk27);                      // Address phase taken
    #1;
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    hwdata = write ? wdata : '0;               // Data phase
    waits  = 0;
    do begin
      @(posedge tb_hclk27);
      #1;
      waits++;
    end while (!hready && waits < 8);
    if (!hready) begin
      err_count++;
      $display("Bridge kept hready low too long at address 0x%08h", addr);
    end
    rdata = hrdata;
    resp  = hresp;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic [1:0]  resp;
    ahb_transfer(1'b1, addr, data, rdata, resp);
    check_value("write response", 32'(HRESP_OKAY), 32'(resp));
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    logic [1:0] resp;
    ahb_transfer(1'b0, addr, '0, data, resp);
    check_value("read response", 32'(HRESP_OKAY), 32'(resp));
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] exp);
    logic [31:0] data;
    bus_read(addr, data);
    check_value(name, exp, data);
  endtask

  // SS low time must be 16 half-periods of div+1 clocks
  always @(negedge tb_hclk27) begin
    if (!n_ss) begin
      ss_low_cycles = ss_low_cycles + 1;
    end else if (ss_low_cycles != 0) begin
      check_value("spi ss low length", 32'(16 * (int'(spi_div) + 1)), 32'(ss_low_cycles));
      ss_low_cycles = 0;
    end
  end

  // ==================================================================
  // Tests
  // ==================================================================
  task automatic reset_values();
    check_value("reset hready", 32'h1, 32'(hready));
    check_value("reset hresp", 32'(HRESP_OKAY), 32'(hresp));
    check_value("reset apb strobes", 32'h0, 32'({apb_subsystem_inst.psel_gpio,
                apb_subsystem_inst.psel_spi, apb_subsystem_inst.penable}));
    check_value("reset gpio n_oe", 32'h0000_ffff, 32'(gpio_n_oe));
    check_value("reset spi pins", 32'h1, 32'({sclk, n_ss}));     // SS high, SCLK low
    check_value("reset irqs", 32'h0, 32'({gpio_irq, spi_irq}));
    read_check("reset gpio out", reg_addr(GPIO_BASE, GPIO_OUT_OFS), '0);
    read_check("reset gpio oe", reg_addr(GPIO_BASE, GPIO_OE_OFS), '0);
    read_check("reset gpio int", reg_addr(GPIO_BASE, GPIO_INT_OFS), '0);
    read_check("reset spi ctrl", reg_addr(SPI_BASE, SPI_CTRL_OFS), '0);
    read_check("reset spi tx", reg_addr(SPI_BASE, SPI_TX_OFS), '0);
    read_check("reset spi rx", reg_addr(SPI_BASE, SPI_RX_OFS), '0);
    read_check("reset spi status", reg_addr(SPI_BASE, SPI_STAT_OFS), '0);
  endtask

  task automatic gpio_register_rw();
    logic [31:0]        word;
    logic [31:0]        val;
    logic [PADDR_W-1:0] ofs;
    for (int i = 0; i < 8; i++) begin
      word = $urandom;
      val  = $urandom;
      ofs  = word[0] ? GPIO_OE_OFS : GPIO_OUT_OFS;
      bus_write(reg_addr(GPIO_BASE, ofs), val);
      gpio_regs[ofs] = val[GPIO_W-1:0];         // Upper half not stored
      read_check("gpio reg readback", reg_addr(GPIO_BASE, ofs), {16'h0, gpio_regs[ofs]});
      check_value("gpio out pins", {16'h0, gpio_regs[GPIO_OUT_OFS]}, {16'h0, gpio_out});
      check_value("gpio n_oe pins", {16'h0, ~gpio_regs[GPIO_OE_OFS]}, {16'h0, gpio_n_oe});
    end
  endtask

  task automatic gpio_input_edges();
    logic [31:0] word;
    for (int i = 0; i < 10; i++) begin
      word = $urandom;
      gpio_regs[GPIO_INT_OFS] |= word[GPIO_W-1:0] & ~gpio_in;   // Rising edges
      gpio_regs[GPIO_IN_OFS]   = word[GPIO_W-1:0];
      gpio_in = word[GPIO_W-1:0];
      repeat (5) @(posedge tb_hclk27);        // Two sync flops, IN, then INT
      #1;
      read_check("gpio in", reg_addr(GPIO_BASE, GPIO_IN_OFS), {16'h0, gpio_regs[GPIO_IN_OFS]});
      read_check("gpio int", reg_addr(GPIO_BASE, GPIO_INT_OFS),
                 {16'h0, gpio_regs[GPIO_INT_OFS]});
      check_value("gpio irq", 32'(|gpio_regs[GPIO_INT_OFS]), 32'(gpio_irq));
      if (i % 3 == 2) begin
        word = $urandom;                        // Write 1 to clear
        bus_write(reg_addr(GPIO_BASE, GPIO_INT_OFS), word);
        gpio_regs[GPIO_INT_OFS] &= ~word[GPIO_W-1:0];
        read_check("gpio int cleared", reg_addr(GPIO_BASE, GPIO_INT_OFS),
                   {16'h0, gpio_regs[GPIO_INT_OFS]});
        check_value("gpio irq cleared", 32'(|gpio_regs[GPIO_INT_OFS]), 32'(gpio_irq));
      end
    end
  endtask

  task automatic set_spi_divider();
    logic [31:0] word;
    word    = $urandom;
    spi_div = {5'h0, word[2:0]};                // Small divider keeps frames short
    bus_write(reg_addr(SPI_BASE, SPI_CTRL_OFS), {23'h0, 1'b1, spi_div});
    read_check("spi ctrl", reg_addr(SPI_BASE, SPI_CTRL_OFS), {23'h0, 1'b1, spi_div});
  endtask

  task automatic spi_frame(input logic [7:0] tx_byte, input logic send_extra,
                           input logic [7:0] extra_byte);
    logic [31:0]         stat;
    logic [SPI_BITS-1:0] exp_byte;
    int                  polls;
    spi_q.push_back(tx_byte);
    bus_write(reg_addr(SPI_BASE, SPI_TX_OFS), {24'h0, tx_byte});
    check_value("spi ss low at start", 32'h0, 32'(n_ss));
    if (send_extra) begin
      bus_write(reg_addr(SPI_BASE, SPI_TX_OFS), {24'h0, extra_byte});   // Dropped
      read_check("spi tx while busy", reg_addr(SPI_BASE, SPI_TX_OFS), {24'h0, tx_byte});
    end
    polls = 0;
    bus_read(reg_addr(SPI_BASE, SPI_STAT_OFS), stat);
    while (stat[0] && polls < 64) begin
      bus_read(reg_addr(SPI_BASE, SPI_STAT_OFS), stat);
      polls++;
    end
    if (stat[0]) begin
      err_count++;
      $display("SPI frame still busy after %0d status polls", polls);
    end
    check_value("spi status at end", 32'h2, stat);               // Done, not busy
    check_value("spi pins at end", 32'h1, 32'({sclk, n_ss}));
    check_value("spi irq at end", 32'h1, 32'(spi_irq));
    exp_byte = spi_q.pop_front();
    read_check("spi rx loopback", reg_addr(SPI_BASE, SPI_RX_OFS), {24'h0, exp_byte});
    read_check("spi status after rx", reg_addr(SPI_BASE, SPI_STAT_OFS), '0);
    check_value("spi irq after rx", 32'h0, 32'(spi_irq));
  endtask

  task automatic unmapped_slots();
    logic [31:0]       word;
    logic [31:0]       addr;
    logic [31:0]       rdata;
    logic [1:0]        resp;
    logic [SLOT_W-1:0] slot;
    for (int i = 0; i < 8; i++) begin
      word = $urandom;
      addr = $urandom;
      slot = 4'(2 + (word % 14));               // Slots 2 to 15
      addr[SLOT_LSB +: SLOT_W] = slot;
      ahb_transfer(word[31], addr, $urandom, rdata, resp);
      check_value("unmapped response", 32'(HRESP_ERROR), 32'(resp));
    end
    // Nothing may have moved
    read_check("gpio out kept", reg_addr(GPIO_BASE, GPIO_OUT_OFS), {16'h0, gpio_regs[0]});
    read_check("gpio oe kept", reg_addr(GPIO_BASE, GPIO_OE_OFS), {16'h0, gpio_regs[1]});
    read_check("gpio int kept", reg_addr(GPIO_BASE, GPIO_INT_OFS), {16'h0, gpio_regs[3]});
    read_check("spi ctrl kept", reg_addr(SPI_BASE, SPI_CTRL_OFS), {23'h0, 1'b1, spi_div});
    read_check("spi status kept", reg_addr(SPI_BASE, SPI_STAT_OFS), '0);
  endtask

  // ==================================================================
  // Run control
  // ==================================================================
  initial begin
    logic [31:0] word;
    void'($urandom(94659));
    hsel        = 1'b0;
    haddr       = '0;
    htrans      = HTRANS_IDLE;
    hwrite      = 1'b0;
    hwdata      = '0;
    hready_in   = 1'b1;
    gpio_in     = '0;
    spi_div     = '0;
    err_count   = 0;
    check_count = 0;
    for (int r = 0; r < 4; r++) begin
      gpio_regs[r] = '0;
    end
    wait (hresetn27 === 1'b1);
    @(posedge tb_hclk27);
    #1;
    reset_values();
    gpio_register_rw();
    gpio_input_edges();
    for (int f = 0; f < NUM_FRAMES - 1; f++) begin
      set_spi_divider();
      word = $urandom;
      spi_frame(word[7:0], 1'b0, 8'h00);
    end
    set_spi_divider();                          // Busy rule frame
    word = $urandom;
    spi_frame(word[7:0], 1'b1, word[15:8]);
    unmapped_slots();
    repeat (4) @(posedge tb_hclk27);
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge tb_hclk27);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
logic/apb_ss_pkg.sv
logic/ahb_apb_bridge.sv
logic/apb_gpio.sv
logic/apb_spi_master.sv
logic/apb_subsystem.sv
dv/tb_clock_gen.sv
dv/apb_subsystem_properties.sv
dv/apb_subsystem_tb.sv

// File: Makefile
# Verilator build and run of the APB subsystem testbench

TOP := apb_subsystem_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): list.f logic/*.sv dv/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if grep -q "%Error" $(LOG); then echo "Simulator reported an error"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
